//--- build.f
common/csr_arch_pkg.sv
common/clint_map_pkg.sv
csr/csr_trap_arbiter.sv
csr/csr_file.sv
clint/clint_timer.sv
design/machine_ctrl_top.sv
sim/machine_ctrl_assertions.sv
sim/machine_ctrl_tb.sv

//--- Makefile
TOP = machine_ctrl_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed" $(LOG)
	@! grep -q "Some tests failed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/machine_ctrl_tb.sv
`timescale 1ns/1ps

module machine_ctrl_tb;
  import csr_arch_pkg::*;
  import clint_map_pkg::*;

  logic clock, reset, crden, cwren, valid, exception, mret_req;
  logic bus_wren, bus_rden, meip, trap, mret;
  csr_addr_t craddr, cwaddr;
  cause_code_t ecause;
  clint_addr_t bus_addr;
  logic [31:0] crdata, cwdata, epc, etval, bus_wdata, bus_rdata, trap_vector, mepc;
  priv_mode_t mode;

  integer seed = 32'hb50e_f651;
  int errors = 0, tests_run = 0, tests_failed = 0, errors_at_start;
  // reference model of the privilege state
  logic st_mie = 1'b0, st_mpie = 1'b0;
  priv_mode_t st_mpp = m_mode, md = m_mode;

  machine_ctrl_top #(.hart_id(32'd5), .tick_divide(4)) u_dut (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] status_word();
    logic [31:0] w;
    w = '0;
    w[status_mie_pos] = st_mie;
    w[status_mpie_pos] = st_mpie;
    w[status_mpp_hi:status_mpp_lo] = st_mpp;
    return w;
  endfunction

  task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_mode(priv_mode_t got, priv_mode_t exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: mode is %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic check_trap(logic pulse, logic [31:0] vec, logic [31:0] exp_vec);
    if (pulse !== 1'b1) begin
      errors++;
      $display("trap pulse did not appear at %0t", $time);
    end else begin
      check_word("trap_vector", vec, exp_vec);
    end
  endtask

  task automatic timeout_fail(string what);
    $display("timeout at %0t: %s", $time, what);
    $display("Some tests failed");
    $finish;
  endtask

  task automatic csr_write(csr_addr_t a, logic [31:0] d);
    cwren = 1'b1;
    cwaddr = a;
    cwdata = d;
    @(negedge clock);
    cwren = 1'b0;
  endtask

  // a read holds its strobe for one cycle and samples mid-cycle
  task automatic csr_read(csr_addr_t a, output logic [31:0] d);
    crden = 1'b1;
    craddr = a;
    #2 d = crdata;
    @(negedge clock);
    crden = 1'b0;
  endtask

  task automatic bus_write(clint_addr_t a, logic [31:0] d);
    bus_wren = 1'b1;
    bus_addr = a;
    bus_wdata = d;
    @(negedge clock);
    bus_wren = 1'b0;
  endtask

  task automatic bus_read(clint_addr_t a, output logic [31:0] d);
    bus_rden = 1'b1;
    bus_addr = a;
    #2 d = bus_rdata;
    @(negedge clock);
    bus_rden = 1'b0;
  endtask

  // which 0 waits for trap, 1 for mret
  task automatic wait_pulse(bit which);
    int n;
    n = 0;
    while ((which ? mret : trap) !== 1'b1 && n < 20) begin
      @(negedge clock);
      n++;
    end
    if ((which ? mret : trap) !== 1'b1) timeout_fail(which ? "no mret pulse" : "no trap pulse");
  endtask

  task automatic model_trap();
    st_mpie = st_mie;
    st_mie = 1'b0;
    st_mpp = md;
    md = m_mode;
  endtask

  task automatic do_mret();
    mret_req = 1'b1;
    @(negedge clock);
    mret_req = 1'b0;
    wait_pulse(1);
    st_mie = st_mpie;
    st_mpie = 1'b1;
    md = st_mpp;
    st_mpp = u_mode;
    check_mode(mode, md);
  endtask

  task automatic quiet_cycles(int n, logic v);
    repeat (n) begin
      valid = v;
      @(negedge clock);
      if (trap !== 1'b0) begin
        errors++;
        $display("unexpected trap at %0t", $time);
      end
    end
    valid = 1'b0;
  endtask

  task automatic reset_and_identity();
    logic [31:0] d;
    csr_read(csr_misa, d);
    check_word("misa", d, misa_value);
    csr_read(csr_mhartid, d);
    check_word("mhartid", d, 32'd5);
    csr_read(csr_mstatus, d);
    check_word("mstatus", d, status_word());
    check_mode(mode, m_mode);
  endtask

  task automatic write_read_regs();
    csr_addr_t addrs[8] = '{csr_mscratch, csr_mtvec, csr_mepc, csr_mcause,
                            csr_mtval, csr_mie, csr_mstatus, csr_mip};
    logic [31:0] d, exp, got;
    int idx;
    repeat (30) begin
      idx = $random(seed) & 7;
      d = $random(seed);
      csr_write(addrs[idx], d);
      exp = d;
      if (idx == 5) exp = d & 32'h0000_0888;
      if (idx == 7) exp = '0;
      if (idx == 6) begin
        st_mie = d[status_mie_pos];
        st_mpie = d[status_mpie_pos];
        if (d[status_mpp_hi:status_mpp_lo] inside {m_mode, u_mode}) begin
          st_mpp = d[status_mpp_hi:status_mpp_lo];
        end
        exp = status_word();
      end
      csr_read(addrs[idx], got);
      check_word("csr readback", got, exp);
    end
  endtask

  task automatic exception_and_mret();
    logic [31:0] base, pc, tv, d;
    cause_code_t ec;
    base = $random(seed) & 32'hffff_fffc;
    ec = $random(seed);
    pc = $random(seed) & 32'hffff_fffc;
    tv = $random(seed);
    csr_write(csr_mtvec, base);
    csr_write(csr_mstatus, 32'h0000_0008);
    {st_mie, st_mpie, st_mpp} = {1'b1, 1'b0, u_mode};
    {exception, valid, ecause, epc, etval} = {1'b1, 1'b1, ec, pc, tv};
    @(negedge clock);
    {exception, valid} = 2'b00;
    wait_pulse(0);
    check_trap(trap, trap_vector, base);
    model_trap();
    @(negedge clock);
    if (trap !== 1'b0) begin
      errors++;
      $display("trap pulse longer than one cycle at %0t", $time);
    end
    check_word("mepc port", mepc, pc);
    csr_read(csr_mepc, d);
    check_word("mepc", d, pc);
    csr_read(csr_mcause, d);
    check_word("mcause", d, {28'b0, ec});
    csr_read(csr_mtval, d);
    check_word("mtval", d, tv);
    csr_read(csr_mstatus, d);
    check_word("mstatus", d, status_word());
    check_mode(mode, m_mode);
    do_mret();
    csr_read(csr_mstatus, d);
    check_word("mstatus", d, status_word());
    // mpp now holds user mode
    do_mret();
  endtask

  task automatic interrupt_priority();
    cause_code_t causes[3] = '{interrupt_mach_extern, interrupt_mach_timer, interrupt_mach_soft};
    logic [31:0] base, d;
    base = $random(seed) & 32'hffff_ff00;
    csr_write(csr_mtvec, base | 32'd1);
    csr_write(csr_mie, 32'h0000_0888);
    csr_write(csr_mstatus, 32'h0);
    {st_mie, st_mpie, st_mpp} = {1'b0, 1'b0, u_mode};
    meip = 1'b1;
    bus_write(clint_msip, 32'd1);
    bus_write(clint_mtimecmp_hi, 32'd0);
    bus_write(clint_mtimecmp_lo, 32'd0);
    quiet_cycles(3, 1'b1);
    csr_write(csr_mstatus, 32'h0000_0008);
    st_mie = 1'b1;
    quiet_cycles(3, 1'b0);
    csr_read(csr_mip, d);
    check_word("mip", d, 32'h0000_0888);
    foreach (causes[i]) begin
      valid = 1'b1;
      @(negedge clock);
      valid = 1'b0;
      wait_pulse(0);
      check_trap(trap, trap_vector, base + 4 * causes[i]);
      model_trap();
      check_mode(mode, m_mode);
      csr_read(csr_mcause, d);
      check_word("mcause", d, {1'b1, 27'b0, causes[i]});
      if (i == 0) meip = 1'b0;
      if (i == 1) bus_write(clint_mtimecmp_hi, 32'hffff_ffff);
      if (i == 2) bus_write(clint_msip, 32'd0);
      do_mret();
      @(negedge clock);
    end
  endtask

  task automatic timer_checks();
    logic [31:0] t0, t1, d;
    int k, n;
    k = 4 * (5 + ($random(seed) & 15));
    bus_read(clint_mtime_lo, t0);
    // the read itself spans one of the k cycles
    repeat (k - 1) @(negedge clock);
    bus_read(clint_mtime_lo, t1);
    check_word("mtime_lo delta", t1 - t0, k / 4);
    bus_read(clint_mtime_lo, t0);
    bus_write(clint_mtimecmp_lo, t0 + 32'd3);
    bus_write(clint_mtimecmp_hi, 32'd0);
    n = 0;
    d = '0;
    while (!d[mtie_pos] && n < 40) begin
      @(negedge clock);
      csr_read(csr_mip, d);
      n++;
    end
    if (!d[mtie_pos]) timeout_fail("timer pending bit never set");
    bus_read(clint_mtime_lo, t1);
    if (t1 < t0 + 32'd3) begin
      errors++;
      $display("timer pending bit set before mtime reached mtimecmp at %0t", $time);
    end
    bus_write(clint_mtimecmp_hi, 32'hffff_ffff);
    bus_write(clint_msip, 32'd1);
    n = 0;
    d = '0;
    while (!d[msie_pos] && n < 10) begin
      @(negedge clock);
      csr_read(csr_mip, d);
      n++;
    end
    if (!d[msie_pos]) timeout_fail("software pending bit never set");
    bus_write(clint_msip, 32'd0);
  endtask

  task automatic counter_checks();
    logic [31:0] i0, i1, c0, c1;
    int v;
    v = 0;
    csr_write(csr_mcountinhibit, 32'd0);
    csr_read(csr_minstret, i0);
    repeat (20) begin
      valid = $random(seed);
      if (valid) v++;
      @(negedge clock);
    end
    valid = 1'b0;
    csr_read(csr_minstret, i1);
    check_word("minstret delta", i1 - i0, v);
    csr_write(csr_mcountinhibit, 32'd5);
    csr_read(csr_mcycle, c0);
    csr_read(csr_minstret, i0);
    quiet_cycles(10, 1'b1);
    csr_read(csr_mcycle, c1);
    check_word("mcycle frozen", c1, c0);
    csr_read(csr_minstret, i1);
    check_word("minstret frozen", i1, i0);
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors != errors_at_start) tests_failed++;
    $display("test %s: %s", name, (errors == errors_at_start) ? "ok" : "FAILED");
    errors_at_start = errors;
  endtask

  initial begin
    {clock, reset, crden, cwren, valid, exception, mret_req} = 7'b0100000;
    {bus_wren, bus_rden, meip} = 3'b000;
    {craddr, cwaddr, cwdata, ecause, epc, etval} = '0;
    {bus_addr, bus_wdata} = '0;
    errors_at_start = 0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    reset_and_identity();
    finish_test("reset and identity");
    write_read_regs();
    finish_test("csr write and read");
    exception_and_mret();
    finish_test("exception and mret");
    interrupt_priority();
    finish_test("interrupt priority");
    timer_checks();
    finish_test("timer");
    counter_checks();
    finish_test("counters");
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- sim/machine_ctrl_assertions.sv
`timescale 1ns/1ps

module machine_ctrl_assertions
  import csr_arch_pkg::*;
(
  input logic       clock,
  input logic       reset,
  input logic       trap,
  input logic       mret,
  input priv_mode_t mode
);

  // both pulses last a single cycle
  trap_single: assert property (@(posedge clock) disable iff (reset) trap |=> !trap)
    else $error("trap high for two cycles");

  mret_single: assert property (@(posedge clock) disable iff (reset) mret |=> !mret)
    else $error("mret high for two cycles");

  reset_quiet: assert property (@(posedge clock) $past(reset) |-> (!trap && !mret))
    else $error("pulse right after reset");

  mode_legal: assert property (@(posedge clock) disable iff (reset)
    (mode == m_mode || mode == u_mode))
    else $error("illegal privilege mode");

endmodule

bind csr_file machine_ctrl_assertions u_assert (
  .clock(clock),
  .reset(reset),
  .trap(trap),
  .mret(mret),
  .mode(mode)
);

//--- design/machine_ctrl_top.sv
`timescale 1ns/1ps

module machine_ctrl_top
  import csr_arch_pkg::*;
  import clint_map_pkg::*;
#(
  parameter logic [31:0] hart_id = 32'h0,
  parameter int tick_divide = 1
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        crden,
  input  csr_addr_t   craddr,
  output logic [31:0] crdata,
  input  logic        cwren,
  input  csr_addr_t   cwaddr,
  input  logic [31:0] cwdata,
  input  logic        valid,
  input  logic        exception,
  input  cause_code_t ecause,
  input  logic [31:0] epc,
  input  logic [31:0] etval,
  input  logic        mret_req,
  input  logic        bus_wren,
  input  logic        bus_rden,
  input  clint_addr_t bus_addr,
  input  logic [31:0] bus_wdata,
  output logic [31:0] bus_rdata,
  input  logic        meip,
  output logic        trap,
  output logic        mret,
  output priv_mode_t  mode,
  output logic [31:0] trap_vector,
  output logic [31:0] mepc
);

  logic        mstatus_mie;
  logic [2:0]  mie_bits;
  logic [2:0]  mip_bits;
  logic        take_trap;
  cause_code_t trap_cause;
  logic        trap_is_interrupt;
  logic        mtip;
  logic        msip;

  csr_file #(
    .hart_id(hart_id)
  ) u_csr (
    .clock(clock), .reset(reset),
    .crden(crden), .craddr(craddr), .crdata(crdata),
    .cwren(cwren), .cwaddr(cwaddr), .cwdata(cwdata),
    .valid(valid), .exception(exception), .ecause(ecause),
    .epc(epc), .etval(etval), .mret_req(mret_req),
    .meip(meip), .mtip(mtip), .msip(msip),
    .take_trap(take_trap), .trap_cause(trap_cause),
    .trap_is_interrupt(trap_is_interrupt),
    .mstatus_mie(mstatus_mie), .mie_bits(mie_bits), .mip_bits(mip_bits),
    .trap(trap), .mret(mret), .mode(mode), .trap_vector(trap_vector),
    .mepc(mepc), .minstret()
  );

  csr_trap_arbiter u_arbiter (
    .mstatus_mie(mstatus_mie), .mie_bits(mie_bits), .mip_bits(mip_bits),
    .valid(valid), .exception(exception), .ecause(ecause),
    .take_trap(take_trap), .trap_cause(trap_cause),
    .trap_is_interrupt(trap_is_interrupt)
  );

  clint_timer #(
    .tick_divide(tick_divide)
  ) u_clint (
    .clock(clock), .reset(reset),
    .bus_wren(bus_wren), .bus_rden(bus_rden), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
    .mtip(mtip), .msip(msip)
  );

endmodule

//--- clint/clint_timer.sv
`timescale 1ns/1ps

module clint_timer
  import clint_map_pkg::*;
#(
  parameter int tick_divide = 1
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        bus_wren,
  input  logic        bus_rden,
  input  clint_addr_t bus_addr,
  input  logic [31:0] bus_wdata,
  output logic [31:0] bus_rdata,
  output logic        mtip,
  output logic        msip
);

  localparam int presc_w = (tick_divide > 1) ? $clog2(tick_divide) : 1;
  localparam logic [presc_w-1:0] presc_last = presc_w'(tick_divide - 1);

  logic [presc_w-1:0] presc;
  logic               tick;
  logic [63:0]        mtime;
  logic [63:0]        mtimecmp;
  logic               msip_reg;

  // with tick_divide of 1 the prescaler stays at zero and ticks every cycle
  assign tick = (presc == presc_last);

  always_ff @(posedge clock) begin
    if (reset) begin
      presc <= '0;
    end else if (tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  // a bus write to either half wins over the tick
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else if (bus_wren && bus_addr == clint_mtime_lo) begin
      mtime <= {mtime[63:32], bus_wdata};
    end else if (bus_wren && bus_addr == clint_mtime_hi) begin
      mtime <= {bus_wdata, mtime[31:0]};
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mtimecmp <= '1;
      msip_reg <= 1'b0;
    end else if (bus_wren) begin
      case (bus_addr)
        clint_msip: msip_reg <= bus_wdata[0];
        clint_mtimecmp_lo: mtimecmp[31:0] <= bus_wdata;
        clint_mtimecmp_hi: mtimecmp[63:32] <= bus_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    bus_rdata = '0;
    if (bus_rden) begin
      case (bus_addr)
        clint_msip: bus_rdata = {31'b0, msip_reg};
        clint_mtimecmp_lo: bus_rdata = mtimecmp[31:0];
        clint_mtimecmp_hi: bus_rdata = mtimecmp[63:32];
        clint_mtime_lo: bus_rdata = mtime[31:0];
        clint_mtime_hi: bus_rdata = mtime[63:32];
        default: bus_rdata = '0;
      endcase
    end
  end

  assign mtip = (mtime >= mtimecmp);
  assign msip = msip_reg;

endmodule

//--- csr/csr_file.sv
`timescale 1ns/1ps

module csr_file
  import csr_arch_pkg::*;
#(
  parameter logic [31:0] hart_id = 32'h0
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        crden,
  input  csr_addr_t   craddr,
  output logic [31:0] crdata,
  input  logic        cwren,
  input  csr_addr_t   cwaddr,
  input  logic [31:0] cwdata,
  input  logic        valid,
  input  logic        exception,
  input  cause_code_t ecause,
  input  logic [31:0] epc,
  input  logic [31:0] etval,
  input  logic        mret_req,
  input  logic        meip,
  input  logic        mtip,
  input  logic        msip,
  input  logic        take_trap,
  input  cause_code_t trap_cause,
  input  logic        trap_is_interrupt,
  output logic        mstatus_mie,
  output logic [2:0]  mie_bits,
  output logic [2:0]  mip_bits,
  output logic        trap,
  output logic        mret,
  output priv_mode_t  mode,
  output logic [31:0] trap_vector,
  output logic [31:0] mepc,
  output logic [63:0] minstret
);

  logic        mstatus_mpie;
  priv_mode_t  mstatus_mpp;
  logic [31:0] mtvec;
  logic [31:0] mscratch;
  logic [31:0] mcause;
  logic [31:0] mtval;
  logic [31:0] mcounteren;
  logic [31:0] mcountinhibit;
  logic [63:0] mcycle;
  logic        trap_int;
  logic [31:0] status_word;
  logic [31:0] mie_word;
  logic [31:0] mip_word;
  priv_mode_t  new_mpp;

  assign new_mpp = cwdata[status_mpp_hi:status_mpp_lo];

  // packed views, mie_bits/mip_bits are ordered {external, timer, software}
  always_comb begin
    status_word = '0;
    status_word[status_mie_pos] = mstatus_mie;
    status_word[status_mpie_pos] = mstatus_mpie;
    status_word[status_mpp_hi:status_mpp_lo] = mstatus_mpp;
    mie_word = '0;
    mie_word[meie_pos] = mie_bits[2];
    mie_word[mtie_pos] = mie_bits[1];
    mie_word[msie_pos] = mie_bits[0];
    mip_word = '0;
    mip_word[meie_pos] = mip_bits[2];
    mip_word[mtie_pos] = mip_bits[1];
    mip_word[msie_pos] = mip_bits[0];
  end

  always_comb begin
    crdata = '0;
    if (crden) begin
      case (craddr)
        csr_mstatus:       crdata = status_word;
        csr_misa:          crdata = misa_value;
        csr_mie:           crdata = mie_word;
        csr_mtvec:         crdata = mtvec;
        csr_mscratch:      crdata = mscratch;
        csr_mepc:          crdata = mepc;
        csr_mcause:        crdata = mcause;
        csr_mtval:         crdata = mtval;
        csr_mip:           crdata = mip_word;
        csr_mcycle:        crdata = mcycle[31:0];
        csr_mcycleh:       crdata = mcycle[63:32];
        csr_minstret:      crdata = minstret[31:0];
        csr_minstreth:     crdata = minstret[63:32];
        csr_mcounteren:    crdata = mcounteren;
        csr_mcountinhibit: crdata = mcountinhibit;
        csr_mvendorid:     crdata = '0;
        csr_marchid:       crdata = '0;
        csr_mimpid:        crdata = '0;
        csr_mhartid:       crdata = hart_id;
        default:           crdata = '0;
      endcase
    end
  end

  // vectored mode only offsets interrupt entries
  always_comb begin
    if (mtvec[1:0] == 2'b01 && trap_int) begin
      trap_vector = {mtvec[31:2] + {26'b0, mcause[3:0]}, 2'b00};
    end else begin
      trap_vector = {mtvec[31:2], 2'b00};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus_mie <= 1'b0;
      mstatus_mpie <= 1'b0;
      mstatus_mpp <= m_mode;
      mode <= m_mode;
      mie_bits <= '0;
      mip_bits <= '0;
      mtvec <= '0;
      mcounteren <= '0;
      mcountinhibit <= '0;
      mcycle <= '0;
      minstret <= '0;
      trap <= 1'b0;
      trap_int <= 1'b0;
      mret <= 1'b0;
    end else begin
      // pending lines arrive one cycle late
      mip_bits <= {meip, mtip, msip};
      trap <= take_trap;
      trap_int <= take_trap & trap_is_interrupt;
      mret <= mret_req & ~take_trap;

      if (!mcountinhibit[0]) begin
        mcycle <= mcycle + 64'd1;
      end
      if (valid && !mcountinhibit[2]) begin
        minstret <= minstret + 64'd1;
      end

      if (cwren) begin
        case (cwaddr)
          csr_mstatus: begin
            mstatus_mie <= cwdata[status_mie_pos];
            mstatus_mpie <= cwdata[status_mpie_pos];
            // mpp keeps its value unless a supported mode is written
            if (new_mpp == m_mode || new_mpp == u_mode) begin
              mstatus_mpp <= new_mpp;
            end
          end
          csr_mie: mie_bits <= {cwdata[meie_pos], cwdata[mtie_pos], cwdata[msie_pos]};
          csr_mtvec: mtvec <= cwdata;
          csr_mcycle: mcycle[31:0] <= cwdata;
          csr_mcycleh: mcycle[63:32] <= cwdata;
          csr_minstret: minstret[31:0] <= cwdata;
          csr_minstreth: minstret[63:32] <= cwdata;
          csr_mcounteren: mcounteren <= cwdata;
          csr_mcountinhibit: mcountinhibit <= cwdata;
          default: ;
        endcase
      end

      if (take_trap) begin
        mstatus_mpie <= mstatus_mie;
        mstatus_mie <= 1'b0;
        mstatus_mpp <= mode;
        mode <= m_mode;
      end else if (mret_req) begin
        mstatus_mie <= mstatus_mpie;
        mstatus_mpie <= 1'b1;
        mode <= mstatus_mpp;
        mstatus_mpp <= u_mode;
      end
    end
  end

  // trap payload
  always_ff @(posedge clock) begin
    if (cwren) begin
      case (cwaddr)
        csr_mscratch: mscratch <= cwdata;
        csr_mepc: mepc <= cwdata;
        csr_mcause: mcause <= cwdata;
        csr_mtval: mtval <= cwdata;
        default: ;
      endcase
    end
    if (take_trap) begin
      mepc <= epc;
      mcause <= {trap_is_interrupt, 27'b0, trap_cause};
      mtval <= exception ? etval : 32'h0;
    end
  end

endmodule

//--- csr/csr_trap_arbiter.sv
`timescale 1ns/1ps

module csr_trap_arbiter
  import csr_arch_pkg::*;
(
  input  logic        mstatus_mie,
  input  logic [2:0]  mie_bits,
  input  logic [2:0]  mip_bits,
  input  logic        valid,
  input  logic        exception,
  input  cause_code_t ecause,
  output logic        take_trap,
  output cause_code_t trap_cause,
  output logic        trap_is_interrupt
);

  // both vectors are ordered {external, timer, software}
  logic [2:0] active;
  logic       irq_ok;

  assign active = mie_bits & mip_bits;

  // interrupts only land on a retiring instruction with global enable set
  assign irq_ok = valid & mstatus_mie & (|active);

  always_comb begin
    take_trap = 1'b0;
    trap_cause = '0;
    trap_is_interrupt = 1'b0;
    if (exception) begin
      take_trap = 1'b1;
      trap_cause = ecause;
    end else if (irq_ok) begin
      take_trap = 1'b1;
      trap_is_interrupt = 1'b1;
      if (active[2]) begin
        trap_cause = interrupt_mach_extern;
      end else if (active[1]) begin
        trap_cause = interrupt_mach_timer;
      end else begin
        trap_cause = interrupt_mach_soft;
      end
    end
  end

endmodule

//--- common/clint_map_pkg.sv
package clint_map_pkg;

  // word offsets on the local timer bus
  typedef logic [3:0] clint_addr_t;

  localparam clint_addr_t clint_msip        = 4'h0;
  localparam clint_addr_t clint_mtimecmp_lo = 4'h2;
  localparam clint_addr_t clint_mtimecmp_hi = 4'h3;
  localparam clint_addr_t clint_mtime_lo    = 4'h4;
  localparam clint_addr_t clint_mtime_hi    = 4'h5;

endpackage

//--- common/csr_arch_pkg.sv
package csr_arch_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [1:0] priv_mode_t;
  typedef logic [3:0] cause_code_t;

  // machine CSR addresses
  localparam csr_addr_t csr_mstatus       = 12'h300;
  localparam csr_addr_t csr_misa          = 12'h301;
  localparam csr_addr_t csr_mie           = 12'h304;
  localparam csr_addr_t csr_mtvec         = 12'h305;
  localparam csr_addr_t csr_mcounteren    = 12'h306;
  localparam csr_addr_t csr_mcountinhibit = 12'h320;
  localparam csr_addr_t csr_mscratch      = 12'h340;
  localparam csr_addr_t csr_mepc          = 12'h341;
  localparam csr_addr_t csr_mcause        = 12'h342;
  localparam csr_addr_t csr_mtval         = 12'h343;
  localparam csr_addr_t csr_mip           = 12'h344;
  localparam csr_addr_t csr_mcycle        = 12'hb00;
  localparam csr_addr_t csr_minstret      = 12'hb02;
  localparam csr_addr_t csr_mcycleh       = 12'hb80;
  localparam csr_addr_t csr_minstreth     = 12'hb82;

  // read-only identity registers
  localparam csr_addr_t csr_mvendorid     = 12'hf11;
  localparam csr_addr_t csr_marchid       = 12'hf12;
  localparam csr_addr_t csr_mimpid        = 12'hf13;
  localparam csr_addr_t csr_mhartid       = 12'hf14;

  localparam priv_mode_t u_mode = 2'b00;
  localparam priv_mode_t m_mode = 2'b11;

  // interrupt cause codes, mcause[31] set on top of these
  localparam cause_code_t interrupt_mach_soft   = 4'd3;
  localparam cause_code_t interrupt_mach_timer  = 4'd7;
  localparam cause_code_t interrupt_mach_extern = 4'd11;

  // mxl = 1 (rv32), extensions I and M, user mode
  localparam logic [31:0] misa_value = 32'h4010_1100;

  // mstatus fields
  localparam int status_mie_pos  = 3;
  localparam int status_mpie_pos = 7;
  localparam int status_mpp_lo   = 11;
  localparam int status_mpp_hi   = 12;

  // mie enables, same layout in mip
  localparam int msie_pos = 3;
  localparam int mtie_pos = 7;
  localparam int meie_pos = 11;

endpackage
